// File: rtl/tune_pkg.sv
package tune_pkg;

    // One-hot pitch class, bit 11 = C down to bit 0 = B
    typedef logic [11:0] note_t;
    localparam note_t NO_NOTE = '0;

    localparam int N_TUNES   = 3;
    localparam int MAX_STEPS = 15;
    localparam int TUNE_W    = $clog2(N_TUNES);

    typedef logic [3:0] step_t;
    localparam step_t RECOGNIZED = 4'hf;

    localparam int SAMPLE_W = 16;
    localparam int PERIOD_W = 20;
    localparam logic [SAMPLE_W-1:0] THRESHOLD = 16'h1100;

    // Standard pitch in Hz times 100, index equals the note bit
    localparam int NOTE_FREQ_100 [11:0] = '{
        26163, 27718, 29366, 31113, 32963, 34923,
        36999, 39200, 41530, 44000, 46616, 49388
    };

    localparam logic [7:0] SEG_OFF = 8'hff;  // Segments are active low

    function automatic logic [7:0] seg_hex(input logic [3:0] value);
        case (value)
            4'h0:    return 8'b00000011;
            4'h1:    return 8'b10011111;
            4'h2:    return 8'b00100101;
            4'h3:    return 8'b00001101;
            4'h4:    return 8'b10011001;
            4'h5:    return 8'b01001001;
            4'h6:    return 8'b01000001;
            4'h7:    return 8'b00011111;
            4'h8:    return 8'b00000001;
            4'h9:    return 8'b00011001;
            4'ha:    return 8'b00010001;
            4'hb:    return 8'b11000001;
            4'hc:    return 8'b01100011;
            4'hd:    return 8'b10000101;
            4'he:    return 8'b01100001;
            default: return 8'b00111001;  // Upper o for a recognized tune
        endcase
    endfunction

    // Letter of the note, dot (h) lit for a sharp
    function automatic logic [7:0] seg_note(input note_t note);
        case (note)
            12'h800: return 8'b01100011;  // C
            12'h400: return 8'b01100010;
            12'h200: return 8'b10000101;  // D
            12'h100: return 8'b10000100;
            12'h080: return 8'b01100001;  // E
            12'h040: return 8'b01110001;  // F
            12'h020: return 8'b01110000;
            12'h010: return 8'b01000011;  // G
            12'h008: return 8'b01000010;
            12'h004: return 8'b00010001;  // A
            12'h002: return 8'b00010000;
            12'h001: return 8'b11000001;  // B
            default: return SEG_OFF;
        endcase
    endfunction

endpackage

// File: rtl/melody_if.sv
`timescale 1ns/1ps

interface melody_if
    import tune_pkg::*;
();

    step_t              step     [N_TUNES];  // Current step of each matcher
    note_t              expected [N_TUNES];  // Note awaited at that step
    logic [N_TUNES-1:0] last;                // Step is the final one of its tune
    logic               clear;               // Table was just rewritten

    // Table side of the lookup
    modport tbl (
        input  step,
        input  clear,
        output expected,
        output last
    );

    modport matcher (
        output step,
        output clear,
        input  expected,
        input  last
    );

endinterface

// File: rtl/mic_spi_rx.sv
`timescale 1ns/1ps

module mic_spi_rx
    import tune_pkg::*;
#(
    parameter int SCK_DIV = 4
)(
    input  logic                clk,
    input  logic                reset,
    output logic                o_cs,
    output logic                o_sck,
    input  logic                i_sdo,
    output logic [SAMPLE_W-1:0] o_sample,
    output logic                o_sample_valid
);

    localparam int DIV_W     = (SCK_DIV > 1) ? $clog2(SCK_DIV) : 1;
    localparam int CS_HALVES = 2 * SAMPLE_W;  // Half SCK periods with CS low
    localparam int LAST_HALF = CS_HALVES + 1;

    logic [DIV_W-1:0]    div_cnt;
    logic [5:0]          half_idx;   // Position in the frame in half SCK periods
    logic [5:0]          half_next;
    logic                tick;
    logic                frame_end;
    logic [SAMPLE_W-1:0] shreg;

    assign tick      = (div_cnt == DIV_W'(SCK_DIV - 1));
    assign half_next = (half_idx == 6'(LAST_HALF)) ? 6'd0 : half_idx + 6'd1;

    // ----------------------------------------
    // Frame timing
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            div_cnt        <= '0;
            half_idx       <= 6'(CS_HALVES);  // Start in the gap with CS high
            o_cs           <= 1'b1;
            o_sck          <= 1'b0;
            frame_end      <= 1'b0;
            o_sample_valid <= 1'b0;
        end
        else
        begin
            div_cnt        <= tick ? '0 : div_cnt + 1'b1;
            frame_end      <= tick && (half_idx == 6'(CS_HALVES - 1));
            o_sample_valid <= frame_end;  // One clock after CS rises
            if (tick)
            begin
                half_idx <= half_next;
                o_cs     <= (half_next >= 6'(CS_HALVES));
                o_sck    <= half_next[0] && (half_next < 6'(CS_HALVES));
            end
        end
    end

    // ----------------------------------------
    // Data path
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        // Take SDO on the clock that raises SCK, MSB first
        if (tick && !half_idx[0] && (half_idx < 6'(CS_HALVES)))
            shreg <= {shreg[SAMPLE_W-2:0], i_sdo};
        if (frame_end)
            o_sample <= shreg;
    end

endmodule

// File: rtl/period_meter.sv
`timescale 1ns/1ps

module period_meter
    import tune_pkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  logic [SAMPLE_W-1:0] i_sample,
    input  logic                i_sample_valid,
    output logic [PERIOD_W-1:0] o_period
);

    logic [SAMPLE_W-1:0] prev_sample;
    logic [PERIOD_W-1:0] count;
    logic                rise;

    // Upward crossing of the threshold
    assign rise = i_sample_valid
               && (i_sample >= THRESHOLD)
               && (prev_sample < THRESHOLD);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            prev_sample <= '0;
            count       <= '0;
            o_period    <= '0;
        end
        else
        begin
            if (i_sample_valid)
                prev_sample <= i_sample;

            if (rise)
            begin
                o_period <= count;
                count    <= PERIOD_W'(1);  // This clock already belongs to the next period
            end
            else if (~&count)                  // Saturate
                count <= count + 1'b1;
        end
    end

endmodule

// File: rtl/note_classifier.sv
`timescale 1ns/1ps

module note_classifier
    import tune_pkg::*;
#(
    parameter int CLK_MHZ = 50
)(
    input  logic                clk,
    input  logic                reset,
    input  logic [PERIOD_W-1:0] i_period,
    output note_t               o_note
);

    localparam int N_CLASSES = $bits(note_t);
    localparam int N_OCTAVES = 3;

    logic [31:0] period_ext;
    note_t       hit;

    assign period_ext = 32'(i_period);

    // ----------------------------------------
    // Window compare for each class and octave
    // ----------------------------------------

    for (genvar n = 0; n < N_CLASSES; n++)
    begin : g_class
        logic [N_OCTAVES-1:0] in_win;

        for (genvar k = 0; k < N_OCTAVES; k++)
        begin : g_octave
            // Hundredth of the period in clocks at this octave
            localparam int NOMINAL = CLK_MHZ * 1000000 / (NOTE_FREQ_100[n] * (1 << k));
            localparam logic [31:0] LOW  = 32'(NOMINAL * 98);
            localparam logic [31:0] HIGH = 32'(NOMINAL * 102);

            assign in_win[k] = (period_ext > LOW) && (period_ext < HIGH);
        end

        assign hit[n] = |in_win;  // Any octave counts
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            o_note <= NO_NOTE;
        else
            o_note <= hit;
    end

endmodule

// File: rtl/note_filter.sv
`timescale 1ns/1ps

module note_filter
    import tune_pkg::*;
#(
    parameter int FILTER_W = 18
)(
    input  logic  clk,
    input  logic  reset,
    input  note_t i_note,
    output note_t o_note
);

    note_t               d_note;      // Note of the previous cycle
    logic [FILTER_W-1:0] stable_cnt;  // Cycles without a change

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            d_note     <= NO_NOTE;
            stable_cnt <= '0;
            o_note     <= NO_NOTE;
        end
        else
        begin
            d_note <= i_note;

            if (i_note != d_note)
                stable_cnt <= '0;
            else if (~&stable_cnt)
                stable_cnt <= stable_cnt + 1'b1;

            if (&stable_cnt)
                o_note <= d_note;  // Held long enough
        end
    end

endmodule

// File: rtl/melody_table.sv
`timescale 1ns/1ps

module melody_table
    import tune_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              i_cfg_we,
    input  logic [TUNE_W-1:0] i_cfg_tune,
    input  step_t             i_cfg_step,
    input  note_t             i_cfg_note,
    input  step_t             i_cfg_len,
    melody_if.tbl             mel
);

    localparam note_t N_C  = 12'h800,
                      N_D  = 12'h200,
                      N_EB = 12'h100,
                      N_E  = 12'h080,
                      N_F  = 12'h040,
                      N_G  = 12'h010,
                      N_AB = 12'h008,
                      N_A  = 12'h004,
                      N_BB = 12'h002,
                      N_B  = 12'h001;

    // Built-in tunes loaded at reset
    localparam note_t BUILTIN [N_TUNES][MAX_STEPS] = '{
        '{N_BB, N_D, N_BB, N_D, N_EB, N_D, N_C, N_A, N_C, N_A, N_C, N_D, N_C, N_BB, N_G},
        '{N_G, N_C, N_EB, N_D, N_C, N_EB, N_C, N_D, N_C, N_AB, N_BB, N_G, N_C, N_EB, N_D},
        '{N_E, N_F, N_E, N_A, N_B, N_C, N_D, N_C, N_B, N_C, N_G, N_C, N_A, N_C, N_A}
    };

    note_t notes [N_TUNES][MAX_STEPS];
    step_t len   [N_TUNES];

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            notes <= BUILTIN;
            len   <= '{default: step_t'(MAX_STEPS)};
        end
        else if (i_cfg_we && (int'(i_cfg_tune) < N_TUNES) && (int'(i_cfg_step) < MAX_STEPS))
        begin
            notes[i_cfg_tune][i_cfg_step] <= i_cfg_note;
            len[i_cfg_tune]               <= i_cfg_len;
        end
    end

    // Lookup for each matcher, silent right after a rewrite
    always_comb
    begin
        for (int t = 0; t < N_TUNES; t++)
        begin
            if (mel.clear || (int'(mel.step[t]) >= MAX_STEPS))
            begin
                mel.expected[t] = NO_NOTE;
                mel.last[t]     = 1'b0;
            end
            else
            begin
                mel.expected[t] = notes[t][mel.step[t]];
                mel.last[t]     = (mel.step[t] == len[t] - 1'b1);
            end
        end
    end

endmodule

// File: rtl/melody_matcher.sv
`timescale 1ns/1ps

module melody_matcher
    import tune_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  note_t     i_note,
    input  logic      i_cfg_we,
    melody_if.matcher mel
);

    logic [N_TUNES-1:0] advance;

    always_comb
    begin
        for (int t = 0; t < N_TUNES; t++)
            advance[t] = (i_note != NO_NOTE)
                      && (mel.step[t] != RECOGNIZED)
                      && (i_note == mel.expected[t]);
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            mel.clear <= 1'b0;
            for (int t = 0; t < N_TUNES; t++)
                mel.step[t] <= '0;
        end
        else
        begin
            mel.clear <= i_cfg_we;  // Table settles one cycle after a write
            for (int t = 0; t < N_TUNES; t++)
            begin
                if (i_cfg_we)
                    mel.step[t] <= '0;
                else if (advance[t])
                    mel.step[t] <= mel.last[t] ? RECOGNIZED : mel.step[t] + 1'b1;
            end
        end
    end

endmodule

// File: rtl/seg_display.sv
`timescale 1ns/1ps

module seg_display
    import tune_pkg::*;
#(
    parameter int SCAN_W = 16
)(
    input  logic       clk,
    input  logic       reset,
    input  note_t      i_note,
    input  step_t      i_steps [N_TUNES],
    output logic [7:0] o_abcdefgh,
    output logic [3:0] o_digit
);

    logic [SCAN_W-1:0] scan_cnt;
    logic              scan_en;
    logic [1:0]        digit_idx;
    logic [1:0]        digit_next;

    assign scan_en    = &scan_cnt;
    assign digit_next = digit_idx + 2'd1;

    // ----------------------------------------
    // Digit scan
    // ----------------------------------------

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scan_cnt   <= '0;
            digit_idx  <= '0;
            o_digit    <= 4'b1111;  // All digits off until the first scan
            o_abcdefgh <= SEG_OFF;
        end
        else
        begin
            scan_cnt <= scan_cnt + 1'b1;

            if (scan_en)
            begin
                digit_idx <= digit_next;
                o_digit   <= ~(4'b0001 << digit_next);

                // Leftmost digit holds the note, then tunes 0, 1, 2
                if (digit_next == 2'd3)
                    o_abcdefgh <= seg_note(i_note);
                else if (int'(digit_next) < N_TUNES)
                    o_abcdefgh <= seg_hex(i_steps[N_TUNES - 1 - int'(digit_next)]);
                else
                    o_abcdefgh <= SEG_OFF;
            end
        end
    end

endmodule

// File: rtl/tune_detector_top.sv
`timescale 1ns/1ps

module tune_detector_top
    import tune_pkg::*;
#(
    parameter int CLK_MHZ  = 50,
    parameter int SCK_DIV  = 4,
    parameter int FILTER_W = 18,
    parameter int SCAN_W   = 16
)(
    input  logic              clk,
    input  logic              reset,
    output logic              o_mic_cs,
    output logic              o_mic_sck,
    input  logic              i_mic_sdo,
    input  logic              i_cfg_we,
    input  logic [TUNE_W-1:0] i_cfg_tune,
    input  step_t             i_cfg_step,
    input  note_t             i_cfg_note,
    input  step_t             i_cfg_len,
    output note_t             o_note,
    output logic [3:0]        o_led,
    output logic [7:0]        o_abcdefgh,
    output logic [3:0]        o_digit
);

    logic [SAMPLE_W-1:0] sample;
    logic                sample_valid;
    logic [PERIOD_W-1:0] period;
    note_t               raw_note;
    note_t               stable_note;
    logic [3:0]          led_next;

    melody_if mel ();

    // ----------------------------------------
    // Pitch path
    // ----------------------------------------

    mic_spi_rx #(.SCK_DIV(SCK_DIV)) u_mic (
        .clk            (clk),
        .reset          (reset),
        .o_cs           (o_mic_cs),
        .o_sck          (o_mic_sck),
        .i_sdo          (i_mic_sdo),
        .o_sample       (sample),
        .o_sample_valid (sample_valid)
    );

    period_meter u_period (
        .clk            (clk),
        .reset          (reset),
        .i_sample       (sample),
        .i_sample_valid (sample_valid),
        .o_period       (period)
    );

    note_classifier #(.CLK_MHZ(CLK_MHZ)) u_classifier (
        .clk      (clk),
        .reset    (reset),
        .i_period (period),
        .o_note   (raw_note)
    );

    note_filter #(.FILTER_W(FILTER_W)) u_filter (
        .clk    (clk),
        .reset  (reset),
        .i_note (raw_note),
        .o_note (stable_note)
    );

    assign o_note = stable_note;

    // ----------------------------------------
    // Melody matching and display
    // ----------------------------------------

    melody_table u_table (
        .clk        (clk),
        .reset      (reset),
        .i_cfg_we   (i_cfg_we),
        .i_cfg_tune (i_cfg_tune),
        .i_cfg_step (i_cfg_step),
        .i_cfg_note (i_cfg_note),
        .i_cfg_len  (i_cfg_len),
        .mel        (mel.tbl)
    );

    melody_matcher u_matcher (
        .clk      (clk),
        .reset    (reset),
        .i_note   (stable_note),
        .i_cfg_we (i_cfg_we),
        .mel      (mel.matcher)
    );

    seg_display #(.SCAN_W(SCAN_W)) u_display (
        .clk        (clk),
        .reset      (reset),
        .i_note     (stable_note),
        .i_steps    (mel.step),
        .o_abcdefgh (o_abcdefgh),
        .o_digit    (o_digit)
    );

    // Tune i on bit 3 - i, bit 0 when every tune is done
    always_comb
    begin
        led_next = '0;
        for (int t = 0; t < N_TUNES; t++)
            led_next[3 - t] = (mel.step[t] == RECOGNIZED);
        led_next[0] = &led_next[3 -: N_TUNES];
    end

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
            o_led <= '0;
        else
            o_led <= led_next;
    end

endmodule

// File: sim/tune_detector_props.sv
`timescale 1ns/1ps

module tune_detector_props (
    input logic        clk,
    input logic        reset,
    input logic [3:0]  i_digit,
    input logic [11:0] i_note,
    input logic        i_mic_cs,
    input logic        i_mic_sck
);

    logic       scanned;    // First digit has been selected
    logic       prev_sck;
    logic [4:0] sck_rises;  // SCK rising edges in the current frame

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            scanned   <= 1'b0;
            prev_sck  <= 1'b0;
            sck_rises <= '0;
        end
        else
        begin
            scanned  <= scanned | (i_digit != 4'hf);
            prev_sck <= i_mic_sck;
            if (i_mic_cs)
                sck_rises <= '0;
            else if (i_mic_sck && !prev_sck)
                sck_rises <= sck_rises + 5'd1;
        end
    end

    a_one_digit: assert property (@(posedge clk) disable iff (reset)
        $onehot(~i_digit) || (!scanned && i_digit == 4'hf))
        else $error("digit select not one-hot");

    a_note_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(i_note))
        else $error("note has more than one bit set");

    a_frame_len: assert property (@(posedge clk) disable iff (reset)
        $rose(i_mic_cs) |-> (sck_rises == 5'd16))
        else $error("CS low for other than 16 SCK periods");

endmodule

bind tune_detector_top tune_detector_props u_props (
    .clk       (clk),
    .reset     (reset),
    .i_digit   (o_digit),
    .i_note    (o_note),
    .i_mic_cs  (o_mic_cs),
    .i_mic_sck (o_mic_sck)
);

// File: sim/tune_detector_tb.sv
`timescale 1ns/1ps

module tune_detector_tb
    import tune_pkg::*;
();

    localparam int CLK_MHZ     = 1;
    localparam int SCK_DIV     = 1;
    localparam int FILTER_W    = 12;
    localparam int SCAN_W      = 3;
    localparam int FRAME_CLKS  = 34 * SCK_DIV;
    localparam int HOLD_CYCLES = 8000;  // Well beyond the filter time
    localparam logic [7:0] SEG_ZERO = 8'b00000011;
    localparam logic [7:0] SEG_DONE = 8'b00111001;  // Upper o

    // Standard pitch times 100 from C up
    localparam int FREQ_100 [12] = '{26163, 27718, 29366, 31113, 32963, 34923,
                                     36999, 39200, 41530, 44000, 46616, 49388};

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              o_mic_cs;
    logic              o_mic_sck;
    logic              i_mic_sdo = 1'b0;
    logic              i_cfg_we = 1'b0;
    logic [TUNE_W-1:0] i_cfg_tune = '0;
    step_t             i_cfg_step = '0;
    note_t             i_cfg_note = NO_NOTE;
    step_t             i_cfg_len = '0;
    note_t             o_note;
    logic [3:0]        o_led;
    logic [7:0]        o_abcdefgh;
    logic [3:0]        o_digit;

    int errors = 0;
    int timeouts = 0;

    // ADC model state
    int          cur_s = 0;         // Frames per period (0 for silence)
    int          req_s = 0;
    int          cur_id = 0;
    int          req_id = 0;
    int          phase = 0;
    int          periods_done = 0;
    logic [3:0]  bit_idx = 4'd15;
    logic [15:0] frame_word;

    always #50 clk = ~clk;

    tune_detector_top #(
        .CLK_MHZ  (CLK_MHZ),
        .SCK_DIV  (SCK_DIV),
        .FILTER_W (FILTER_W),
        .SCAN_W   (SCAN_W)
    ) u_dut (.*);

    // ----------------------------------------
    // Microphone ADC model
    // ----------------------------------------

    assign frame_word = (cur_s != 0 && phase < cur_s / 2) ? 16'h8000 : 16'h0000;

    always @(posedge clk)
    begin
        if (reset)
        begin
            i_mic_sdo <= 1'b0;
            bit_idx   <= 4'd15;
        end
        else if (o_mic_cs)
        begin
            i_mic_sdo <= frame_word[15];  // MSB ready before the first SCK rise
            bit_idx   <= 4'd15;
        end
        else if (o_mic_sck)
        begin
            if (bit_idx != 4'd0)
            begin
                i_mic_sdo <= frame_word[bit_idx - 4'd1];
                bit_idx   <= bit_idx - 4'd1;
            end
            else if (cur_s == 0 || phase == cur_s - 1)
            begin
                // New tone only starts on a period boundary
                phase <= 0;
                if (req_id != cur_id)
                begin
                    cur_s        <= req_s;
                    cur_id       <= req_id;
                    periods_done <= 0;
                end
                else
                    periods_done <= periods_done + 1;
            end
            else
                phase <= phase + 1;
        end
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------

    function automatic int nominal(input int cls, input int oct);
        return CLK_MHZ * 1000000 / (FREQ_100[cls] * (1 << oct));
    endfunction

    function automatic note_t note_of(input int cls);
        return note_t'(12'h800 >> cls);
    endfunction

    // Pitch class that the window rule gives for a period
    function automatic note_t window_note(input int period);
        note_t n;
        n = NO_NOTE;
        for (int cls = 0; cls < 12; cls++)
            for (int oct = 0; oct < 3; oct++)
                if (period > nominal(cls, oct) * 98 && period < nominal(cls, oct) * 102)
                    n[11 - cls] = 1'b1;
        return n;
    endfunction

    task automatic play_samples(input int samples, input int cycles,
                                input logic hold_en, input note_t hold_note);
        int   n;
        int   limit;
        int   waited;
        logic reported;
        n        = (cycles + samples * FRAME_CLKS - 1) / (samples * FRAME_CLKS);
        limit    = (n + 2) * samples * FRAME_CLKS * 2 + 1000;
        waited   = 0;
        reported = 1'b0;
        @(posedge clk);
        req_s  <= samples;
        req_id <= req_id + 1;
        // Return once the last period has begun so that the next tone follows it
        do
        begin
            @(posedge clk);
            waited++;
            if (hold_en && !reported && o_note != hold_note)
            begin
                errors++;
                reported = 1'b1;
                $display("FAILED at %0t: o_note %h changed, expected %h", $time, o_note,
                         hold_note);
            end
        end while (!(cur_id == req_id && periods_done >= n - 1) && waited < limit);
        if (waited >= limit)
        begin
            timeouts++;
            $display("Timeout while playing a tone of %0d frames per period", samples);
        end
    endtask

    task automatic play_note(input int cls, input int oct, input int cycles,
                             input logic hold_en = 1'b0, input note_t hold_note = NO_NOTE);
        int nom;
        int s;
        nom = nominal(cls, oct);
        s   = (nom * 100 + FRAME_CLKS / 2) / FRAME_CLKS;  // Rounded frames per period
        if (!(s * FRAME_CLKS > nom * 98 && s * FRAME_CLKS < nom * 102))
        begin
            errors++;
            $display("FAILED at %0t: period %0d outside window of class %0d", $time,
                     s * FRAME_CLKS, cls);
        end
        play_samples(s, cycles, hold_en, hold_note);
    endtask

    task automatic wait_note(input note_t expected, input int limit);
        int waited;
        waited = 0;
        while (o_note != expected && waited < limit)
        begin
            @(posedge clk);
            waited++;
        end
        if (o_note != expected)
        begin
            errors++;
            $display("FAILED at %0t: o_note %h, expected %h", $time, o_note, expected);
        end
    endtask

    task automatic wait_led(input logic [3:0] mask, input logic [3:0] value, input int limit);
        int waited;
        waited = 0;
        while ((o_led & mask) != value && waited < limit)
        begin
            @(posedge clk);
            waited++;
        end
        if ((o_led & mask) != value)
        begin
            errors++;
            $display("FAILED at %0t: o_led %b, expected %b under mask %b", $time, o_led,
                     value, mask);
        end
    endtask

    task automatic wait_digit(input logic [3:0] digit);
        int waited;
        waited = 0;
        do
        begin
            @(posedge clk);
            waited++;
        end while (o_digit != digit && waited < 64 * (1 << SCAN_W));
        if (o_digit != digit)
        begin
            timeouts++;
            $display("Timeout waiting for digit select %b", digit);
        end
    endtask

    task automatic write_cfg(input int tune, input int step, input int cls, input int len);
        @(posedge clk);
        i_cfg_we   <= 1'b1;
        i_cfg_tune <= TUNE_W'(tune);
        i_cfg_step <= step_t'(step);
        i_cfg_note <= note_of(cls);
        i_cfg_len  <= step_t'(len);
        @(posedge clk);
        i_cfg_we   <= 1'b0;
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------

    task automatic test_reset();
        if (o_led != 4'b0000)
        begin
            errors++;
            $display("FAILED at %0t: o_led %b after reset", $time, o_led);
        end
        if (o_note != NO_NOTE)
        begin
            errors++;
            $display("FAILED at %0t: o_note %h after reset", $time, o_note);
        end
        for (int i = 0; i < 8 * (1 << SCAN_W); i++)
        begin
            @(posedge clk);
            if (o_abcdefgh != SEG_OFF && o_abcdefgh != SEG_ZERO)
            begin
                errors++;
                $display("FAILED at %0t: segments %b after reset", $time, o_abcdefgh);
            end
        end
    endtask

    task automatic test_classify();
        int cls_list [6];
        int oct_list [6];
        int s_off;
        cls_list = '{0, 4, 7, 9, 11, 2};
        oct_list = '{0, 1, 0, 1, 0, 0};
        // C played 5% low falls in no window
        s_off = ((nominal(0, 0) * 100 + FRAME_CLKS / 2) / FRAME_CLKS * 105 + 50) / 100;
        if (window_note(s_off * FRAME_CLKS) != NO_NOTE)
        begin
            errors++;
            $display("FAILED at %0t: off-pitch period %0d hits a window", $time,
                     s_off * FRAME_CLKS);
        end
        play_samples(s_off, 2 * HOLD_CYCLES, 1'b1, NO_NOTE);
        for (int i = 0; i < 6; i++)
        begin
            play_note(cls_list[i], oct_list[i], HOLD_CYCLES);
            wait_note(note_of(cls_list[i]), 5000);
        end
    endtask

    task automatic test_filter();
        play_note(7, 0, 1, 1'b1, note_of(2));       // One G period only
        play_note(2, 0, HOLD_CYCLES, 1'b1, note_of(2));
        play_note(7, 0, HOLD_CYCLES);
        wait_note(note_of(7), 5000);
    endtask

    task automatic test_reprogram();
        write_cfg(2, 0, 0, 3);
        write_cfg(2, 1, 4, 3);
        write_cfg(2, 2, 7, 3);
        play_note(4, 0, HOLD_CYCLES);               // E C G is the wrong order
        play_note(0, 0, HOLD_CYCLES);
        play_note(7, 0, HOLD_CYCLES);
        wait_note(note_of(7), 5000);
        repeat (4) @(posedge clk);
        if (o_led[1] != 1'b0)
        begin
            errors++;
            $display("FAILED at %0t: tune 2 recognized out of order", $time);
        end
        write_cfg(2, 0, 0, 3);                      // Clears all steps
        play_note(0, 0, HOLD_CYCLES);
        play_note(4, 0, HOLD_CYCLES);
        play_note(7, 0, HOLD_CYCLES);
        wait_led(4'b0010, 4'b0010, 5000);
        wait_digit(4'b1101);
        wait_digit(4'b1110);
        if (o_abcdefgh != SEG_DONE)
        begin
            errors++;
            $display("FAILED at %0t: digit 0 shows %b", $time, o_abcdefgh);
        end
    endtask

    task automatic test_builtin();
        int tune0 [15];
        tune0 = '{10, 2, 10, 2, 3, 2, 0, 9, 0, 9, 0, 2, 0, 10, 7};
        write_cfg(1, 0, 10, 2);                     // Short prefixes of tune 0
        write_cfg(1, 1, 2, 2);
        write_cfg(2, 0, 10, 1);
        for (int i = 0; i < 15; i++)
        begin
            play_note(tune0[i], 0, HOLD_CYCLES);
            if (i == 0)
                wait_led(4'b0010, 4'b0010, 5000);
            if (i == 1)
                wait_led(4'b0100, 4'b0100, 5000);
        end
        wait_led(4'b1111, 4'b1111, 5000);
        write_cfg(0, 0, 10, 15);
        wait_led(4'b1111, 4'b0000, 10);
    endtask

    initial
    begin
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_reset();
        test_classify();
        test_filter();
        test_reprogram();
        test_builtin();
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: tune_detector.f
rtl/tune_pkg.sv
rtl/melody_if.sv
rtl/mic_spi_rx.sv
rtl/period_meter.sv
rtl/note_classifier.sv
rtl/note_filter.sv
rtl/melody_table.sv
rtl/melody_matcher.sv
rtl/seg_display.sv
rtl/tune_detector_top.sv
sim/tune_detector_props.sv
sim/tune_detector_tb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= tune_detector.f
TOP       ?= tune_detector_tb
RTL_TOP   ?= tune_detector_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Test failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
